// File: Makefile
SIM      := verilator
TOP      := tb_ccu_master_path
FILELIST := ccu_master_path.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ccu_master_path.f
rtl/ccu_pkg.sv
rtl/ccu_fifo.sv
rtl/ccu_req_decoder.sv
rtl/ccu_snoop_path.sv
rtl/ccu_mem_port.sv
rtl/ccu_master_path.sv
tests/tb_ccu_master_path.sv

// File: rtl/ccu_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ccu_fifo #(
  parameter int unsigned Depth = 4,
  parameter type payload_t     = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;

  function automatic logic [PtrWidth-1:0] ptr_next(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) wptr_q <= ptr_next(wptr_q);
      if (pop_i) rptr_q <= ptr_next(rptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + CntWidth'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - CntWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wptr_q] <= data_i;
  end

  // head of the queue is visible before it is popped
  assign data_o  = mem_q[rptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));

  // the producers have no back-pressure, so sizing must keep the queue from filling
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("ccu_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("ccu_fifo: pop while empty");

endmodule

`default_nettype wire

// File: rtl/ccu_master_path.sv
`timescale 1ns/1ns
`default_nettype none

module ccu_master_path #(
  parameter int unsigned NoMasters        = 4,
  parameter int unsigned NoMasterPerGroup = 2,
  parameter int unsigned FifoDepth        = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NoMasters-1:0]                req_valid_i,
  input  ccu_pkg::ccu_req_t [NoMasters-1:0]   req_i,
  output logic [NoMasters-1:0]                rsp_valid_o,
  output ccu_pkg::ccu_rsp_t [NoMasters-1:0]   rsp_o,
  output logic [NoMasters-1:0]                snoop_valid_o,
  output ccu_pkg::snoop_req_t [NoMasters-1:0] snoop_o,
  input  logic [NoMasters-1:0]                snoop_rsp_valid_i,
  input  ccu_pkg::snoop_rsp_t [NoMasters-1:0] snoop_rsp_i,
  output logic                                mem_valid_o,
  output ccu_pkg::mem_req_t                   mem_req_o,
  input  logic                                mem_rsp_valid_i,
  input  ccu_pkg::ccu_rsp_t                   mem_rsp_i
);

  import ccu_pkg::*;

  // group membership is fixed by position
  localparam int unsigned NoGroups = NoMasters / NoMasterPerGroup;

  logic [NoMasters-1:0]     snp_valid;
  ccu_req_t [NoMasters-1:0] snp_req;
  logic [NoMasters-1:0]     dec_mem_valid;
  mem_req_t [NoMasters-1:0] dec_mem_req;
  logic [NoGroups-1:0]      grp_mem_valid;
  mem_req_t [NoGroups-1:0]  grp_mem_req;
  logic [NoGroups-1:0]      hit_valid;
  ccu_rsp_t [NoGroups-1:0]  hit_rsp;

  ccu_req_decoder #(
    .NoMasters        (NoMasters),
    .NoMasterPerGroup (NoMasterPerGroup)
  ) i_req_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .snp_valid_o (snp_valid),
    .snp_req_o   (snp_req),
    .mem_valid_o (dec_mem_valid),
    .mem_req_o   (dec_mem_req)
  );

  for (genvar g = 0; g < NoGroups; g++) begin : gen_group
    ccu_snoop_path #(
      .NoMasterPerGroup (NoMasterPerGroup),
      .GroupBase        (g * NoMasterPerGroup),
      .FifoDepth        (FifoDepth)
    ) i_snoop_path (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .req_valid_i       (snp_valid[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .req_i             (snp_req[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .snoop_valid_o     (snoop_valid_o[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .snoop_o           (snoop_o[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .snoop_rsp_valid_i (snoop_rsp_valid_i[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .snoop_rsp_i       (snoop_rsp_i[g*NoMasterPerGroup +: NoMasterPerGroup]),
      .mem_valid_o       (grp_mem_valid[g]),
      .mem_req_o         (grp_mem_req[g]),
      .hit_valid_o       (hit_valid[g]),
      .hit_rsp_o         (hit_rsp[g])
    );
  end

  // non-snooping lanes first, then one lane per group
  ccu_mem_port #(
    .NoMasters (NoMasters),
    .NoGroups  (NoGroups),
    .FifoDepth (FifoDepth)
  ) i_mem_port (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .lane_valid_i    ({grp_mem_valid, dec_mem_valid}),
    .lane_req_i      ({grp_mem_req, dec_mem_req}),
    .hit_valid_i     (hit_valid),
    .hit_rsp_i       (hit_rsp),
    .mem_valid_o     (mem_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o)
  );

endmodule

`default_nettype wire

// File: rtl/ccu_mem_port.sv
`timescale 1ns/1ns
`default_nettype none

module ccu_mem_port #(
  parameter int unsigned NoMasters = 4,
  parameter int unsigned NoGroups  = 2,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic [NoMasters+NoGroups-1:0]              lane_valid_i,
  input  ccu_pkg::mem_req_t [NoMasters+NoGroups-1:0] lane_req_i,
  input  logic [NoGroups-1:0]                        hit_valid_i,
  input  ccu_pkg::ccu_rsp_t [NoGroups-1:0]           hit_rsp_i,
  output logic                                       mem_valid_o,
  output ccu_pkg::mem_req_t                          mem_req_o,
  input  logic                                       mem_rsp_valid_i,
  input  ccu_pkg::ccu_rsp_t                          mem_rsp_i,
  output logic [NoMasters-1:0]                       rsp_valid_o,
  output ccu_pkg::ccu_rsp_t [NoMasters-1:0]          rsp_o
);

  import ccu_pkg::*;

  localparam int          NoLanes   = NoMasters + NoGroups;
  localparam int unsigned LaneWidth = $clog2(NoLanes);

  logic [NoLanes-1:0]     lane_empty;
  logic [NoLanes-1:0]     lane_pop;
  mem_req_t [NoLanes-1:0] lane_head;
  logic [LaneWidth-1:0]   rr_q;
  logic [LaneWidth-1:0]   sel;
  logic                   sel_valid;

  logic [NoGroups-1:0]     hit_hold_q;
  ccu_rsp_t [NoGroups-1:0] hit_rsp_q;
  logic [NoGroups-1:0]     hit_grant;
  ccu_rsp_t                hit_push_data;
  ccu_rsp_t                hit_head;
  logic                    hit_empty;
  logic                    hit_pop;
  ccu_rsp_t                rsp_sel;
  logic                    rsp_any;
  ccu_rsp_t                rsp_q;

  for (genvar l = 0; l < NoLanes; l++) begin : gen_lane
    ccu_fifo #(
      .Depth     (FifoDepth),
      .payload_t (mem_req_t)
    ) i_lane_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (lane_valid_i[l]),
      .data_i  (lane_req_i[l]),
      .pop_i   (lane_pop[l]),
      .data_o  (lane_head[l]),
      .empty_o (lane_empty[l]),
      .full_o  ()
    );
  end

  // search starts at the lane after the last grant
  always_comb begin
    int idx;
    sel       = '0;
    sel_valid = 1'b0;
    for (int k = NoLanes - 1; k >= 0; k--) begin
      idx = int'(rr_q) + k;
      if (idx >= NoLanes) idx = idx - NoLanes;
      if (!lane_empty[idx]) begin
        sel       = LaneWidth'(idx);
        sel_valid = 1'b1;
      end
    end
    lane_pop      = '0;
    lane_pop[sel] = sel_valid;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (sel_valid) begin
      rr_q <= (sel == LaneWidth'(NoLanes - 1)) ? '0 : sel + LaneWidth'(1);
    end
  end

  assign mem_valid_o = sel_valid;
  assign mem_req_o   = lane_head[sel];

  // a group resolves at most once every few cycles, so one holding slot per group is enough
  always_comb begin
    hit_grant     = '0;
    hit_push_data = '0;
    for (int g = NoGroups - 1; g >= 0; g--) begin
      if (hit_hold_q[g]) begin
        hit_grant     = '0;
        hit_grant[g]  = 1'b1;
        hit_push_data = hit_rsp_q[g];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hit_hold_q <= '0;
    end else begin
      hit_hold_q <= (hit_hold_q & ~hit_grant) | hit_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int g = 0; g < NoGroups; g++) begin
      if (hit_valid_i[g]) hit_rsp_q[g] <= hit_rsp_i[g];
    end
  end

  ccu_fifo #(
    .Depth     (FifoDepth),
    .payload_t (ccu_rsp_t)
  ) i_hit_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (|hit_hold_q),
    .data_i  (hit_push_data),
    .pop_i   (hit_pop),
    .data_o  (hit_head),
    .empty_o (hit_empty),
    .full_o  ()
  );

  // memory answers win, queued hits use the idle cycles
  assign hit_pop = !mem_rsp_valid_i && !hit_empty;
  assign rsp_any = mem_rsp_valid_i || !hit_empty;
  assign rsp_sel = mem_rsp_valid_i ? mem_rsp_i : hit_head;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= '0;
    end else begin
      for (int m = 0; m < NoMasters; m++) begin
        rsp_valid_o[m] <= rsp_any && (rsp_sel.id == id_t'(m));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_any) rsp_q <= rsp_sel;
  end

  assign rsp_o = {NoMasters{rsp_q}};

endmodule

`default_nettype wire

// File: rtl/ccu_pkg.sv
`default_nettype none

package ccu_pkg;

  localparam int unsigned AddrWidth  = 16;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned MaxMasters = 8;
  // index of the originating master, wide enough for every master
  localparam int unsigned IdWidth    = $clog2(MaxMasters);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  // bit 0 marks a coherent op, bit 1 marks a write
  typedef enum logic [1:0] {
    OpReadNoSnoop  = 2'b00,
    OpReadShared   = 2'b01,
    OpWriteNoSnoop = 2'b10,
    OpWriteUnique  = 2'b11
  } ccu_op_e;

  typedef struct packed {
    ccu_op_e op;
    addr_t   addr;
    data_t   data;
  } ccu_req_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
    id_t   id;
  } mem_req_t;

  typedef struct packed {
    id_t   id;
    data_t data;
  } ccu_rsp_t;

  typedef struct packed {
    addr_t addr;
    logic  invalidate;
  } snoop_req_t;

  typedef struct packed {
    logic  hit;
    data_t data;
  } snoop_rsp_t;

endpackage

`default_nettype wire

// File: rtl/ccu_req_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module ccu_req_decoder #(
  parameter int unsigned NoMasters        = 4,
  parameter int unsigned NoMasterPerGroup = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [NoMasters-1:0]              req_valid_i,
  input  ccu_pkg::ccu_req_t [NoMasters-1:0] req_i,
  output logic [NoMasters-1:0]              snp_valid_o,
  output ccu_pkg::ccu_req_t [NoMasters-1:0] snp_req_o,
  output logic [NoMasters-1:0]              mem_valid_o,
  output ccu_pkg::mem_req_t [NoMasters-1:0] mem_req_o
);

  import ccu_pkg::*;

  // a group of one has no peer cache, so its coherent ops go straight to memory
  localparam bit HasPeers = (NoMasterPerGroup > 1);

  logic [NoMasters-1:0] snooping;

  always_comb begin
    for (int m = 0; m < NoMasters; m++) begin
      snooping[m] = HasPeers && (req_i[m].op inside {OpReadShared, OpWriteUnique});
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      snp_valid_o <= '0;
      mem_valid_o <= '0;
    end else begin
      snp_valid_o <= req_valid_i & snooping;
      mem_valid_o <= req_valid_i & ~snooping;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NoMasters; m++) begin
      if (req_valid_i[m]) begin
        snp_req_o[m]       <= req_i[m];
        mem_req_o[m].write <= req_i[m].op inside {OpWriteNoSnoop, OpWriteUnique};
        mem_req_o[m].addr  <= req_i[m].addr;
        mem_req_o[m].data  <= req_i[m].data;
        mem_req_o[m].id    <= id_t'(m);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ccu_snoop_path.sv
`timescale 1ns/1ns
`default_nettype none

module ccu_snoop_path #(
  parameter int unsigned NoMasterPerGroup = 2,
  parameter int unsigned GroupBase        = 0,
  parameter int unsigned FifoDepth        = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic [NoMasterPerGroup-1:0]                req_valid_i,
  input  ccu_pkg::ccu_req_t [NoMasterPerGroup-1:0]   req_i,
  output logic [NoMasterPerGroup-1:0]                snoop_valid_o,
  output ccu_pkg::snoop_req_t [NoMasterPerGroup-1:0] snoop_o,
  input  logic [NoMasterPerGroup-1:0]                snoop_rsp_valid_i,
  input  ccu_pkg::snoop_rsp_t [NoMasterPerGroup-1:0] snoop_rsp_i,
  output logic                                       mem_valid_o,
  output ccu_pkg::mem_req_t                          mem_req_o,
  output logic                                       hit_valid_o,
  output ccu_pkg::ccu_rsp_t                          hit_rsp_o
);

  import ccu_pkg::*;

  localparam int unsigned SrcWidth = (NoMasterPerGroup > 1) ? $clog2(NoMasterPerGroup) : 1;

  // queued request tagged with its position inside the group
  typedef struct packed {
    ccu_req_t            req;
    logic [SrcWidth-1:0] src;
  } grp_req_t;

  typedef enum logic [1:0] {StIdle, StSnoop, StWait, StResolve} state_e;

  logic [NoMasterPerGroup-1:0]     hold_valid_q;
  ccu_req_t [NoMasterPerGroup-1:0] hold_req_q;
  logic [NoMasterPerGroup-1:0]     grant;
  grp_req_t                        push_data;
  grp_req_t                        head;
  logic                            fifo_empty;
  logic                            pop;

  state_e                          state_q;
  grp_req_t                        cur_q;
  logic [NoMasterPerGroup-1:0]     pending_q;
  logic [NoMasterPerGroup-1:0]     hit_q;
  data_t [NoMasterPerGroup-1:0]    snp_data_q;
  logic [NoMasterPerGroup-1:0]     peers;
  data_t                           hit_data;
  logic                            read_hit;
  id_t                             req_id;
  snoop_req_t                      snoop_req;

  // simultaneous group requests wait here, lowest index enters the queue first
  always_comb begin
    grant     = '0;
    push_data = '0;
    for (int j = NoMasterPerGroup - 1; j >= 0; j--) begin
      if (hold_valid_q[j]) begin
        grant         = '0;
        grant[j]      = 1'b1;
        push_data.req = hold_req_q[j];
        push_data.src = SrcWidth'(j);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= '0;
    end else begin
      hold_valid_q <= (hold_valid_q & ~grant) | req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int j = 0; j < NoMasterPerGroup; j++) begin
      if (req_valid_i[j]) hold_req_q[j] <= req_i[j];
    end
  end

  ccu_fifo #(
    .Depth     (FifoDepth),
    .payload_t (grp_req_t)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (|hold_valid_q),
    .data_i  (push_data),
    .pop_i   (pop),
    .data_o  (head),
    .empty_o (fifo_empty),
    .full_o  ()
  );

  assign pop = (state_q == StIdle) && !fifo_empty;

  always_comb begin
    peers            = '1;
    peers[cur_q.src] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= StIdle;
      pending_q <= '0;
      hit_q     <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (pop) state_q <= StSnoop;
        end
        StSnoop: begin
          pending_q <= peers;
          hit_q     <= '0;
          state_q   <= StWait;
        end
        StWait: begin
          pending_q <= pending_q & ~snoop_rsp_valid_i;
          for (int j = 0; j < NoMasterPerGroup; j++) begin
            if (snoop_rsp_valid_i[j] && snoop_rsp_i[j].hit) hit_q[j] <= 1'b1;
          end
          if ((pending_q & ~snoop_rsp_valid_i) == '0) state_q <= StResolve;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) cur_q <= head;
    for (int j = 0; j < NoMasterPerGroup; j++) begin
      if (snoop_rsp_valid_i[j]) snp_data_q[j] <= snoop_rsp_i[j].data;
    end
  end

  // lowest-index hitting peer supplies the line
  always_comb begin
    hit_data = '0;
    for (int j = NoMasterPerGroup - 1; j >= 0; j--) begin
      if (hit_q[j]) hit_data = snp_data_q[j];
    end
  end

  assign snoop_req.addr       = cur_q.req.addr;
  assign snoop_req.invalidate = (cur_q.req.op == OpWriteUnique);
  assign snoop_o              = {NoMasterPerGroup{snoop_req}};
  assign snoop_valid_o        = (state_q == StSnoop) ? peers : '0;

  assign req_id   = id_t'(GroupBase + cur_q.src);
  assign read_hit = (cur_q.req.op == OpReadShared) && (|hit_q);

  assign hit_valid_o    = (state_q == StResolve) && read_hit;
  assign hit_rsp_o.id   = req_id;
  assign hit_rsp_o.data = hit_data;

  assign mem_valid_o     = (state_q == StResolve) && !read_hit;
  assign mem_req_o.write = (cur_q.req.op == OpWriteUnique);
  assign mem_req_o.addr  = cur_q.req.addr;
  assign mem_req_o.data  = cur_q.req.data;
  assign mem_req_o.id    = req_id;

  // each cache answer must match a snoop this group still waits for
  a_rsp_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (snoop_rsp_valid_i & ~pending_q) == '0)
    else $error("ccu_snoop_path: snoop answer without a pending snoop");

endmodule

`default_nettype wire

// File: tests/tb_ccu_master_path.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ccu_master_path;

  import ccu_pkg::*;

  localparam int NoMasters        = 4;
  localparam int NoMasterPerGroup = 2;
  localparam int FifoDepth        = 4;
  localparam int NoGroups         = NoMasters / NoMasterPerGroup;
  localparam int NumRounds        = 24;
  // directed tests issue 3 per master plus 4 per group
  localparam int NumTxn           = 3 * NoMasters + 4 * NoGroups + NumRounds * NoMasters;

  typedef logic [IdWidth+AddrWidth-1:0] line_key_t;

  typedef struct packed {
    mem_req_t    req;
    int unsigned due;
  } mem_job_t;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic [NoMasters-1:0]       req_valid_i;
  ccu_req_t [NoMasters-1:0]   req_i;
  logic [NoMasters-1:0]       rsp_valid_o;
  ccu_rsp_t [NoMasters-1:0]   rsp_o;
  logic [NoMasters-1:0]       snoop_valid_o;
  snoop_req_t [NoMasters-1:0] snoop_o;
  logic [NoMasters-1:0]       snoop_rsp_valid_i = '0;
  snoop_rsp_t [NoMasters-1:0] snoop_rsp_i = '0;
  logic                       mem_valid_o;
  mem_req_t                   mem_req_o;
  logic                       mem_rsp_valid_i = 1'b0;
  ccu_rsp_t                   mem_rsp_i = '0;

  data_t                mem_store [addr_t];
  data_t                cache_store [line_key_t];
  mem_job_t             mem_jobs [$];
  int unsigned          cycle_cnt = 0;
  logic [NoMasters-1:0] busy = '0;
  ccu_req_t             cur_req [NoMasters];
  ccu_rsp_t             exp_rsp [NoMasters];
  bit                   exp_read [NoMasters];
  int                   snoop_count [NoMasters];
  int                   mem_count [NoMasters];
  int                   errors = 0;
  int                   checks = 0;
  int                   tests_run = 0;
  int                   tests_bad = 0;

  ccu_master_path #(
    .NoMasters        (NoMasters),
    .NoMasterPerGroup (NoMasterPerGroup),
    .FifoDepth        (FifoDepth)
  ) dut0 (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_valid_i       (req_valid_i),
    .req_i             (req_i),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_o             (rsp_o),
    .snoop_valid_o     (snoop_valid_o),
    .snoop_o           (snoop_o),
    .snoop_rsp_valid_i (snoop_rsp_valid_i),
    .snoop_rsp_i       (snoop_rsp_i),
    .mem_valid_o       (mem_valid_o),
    .mem_req_o         (mem_req_o),
    .mem_rsp_valid_i   (mem_rsp_valid_i),
    .mem_rsp_i         (mem_rsp_i)
  );

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  function automatic int group_base(int m);
    return (m / NoMasterPerGroup) * NoMasterPerGroup;
  endfunction

  function automatic line_key_t cache_key(int m, addr_t a);
    return {id_t'(m), a};
  endfunction

  // untouched memory holds a pattern made from the whole address
  function automatic data_t mem_read(addr_t a);
    if (mem_store.exists(a)) return mem_store[a];
    return {~a, a};
  endfunction

  function automatic addr_t region_addr(int m, int offset);
    return addr_t'(32'h1000 * (m + 1) + offset);
  endfunction

  // ReadShared takes the lowest-index peer that holds the line, all other reads see memory
  function automatic ccu_rsp_t expect_rsp(int m, ccu_req_t req);
    ccu_rsp_t rsp;
    bit       found;
    rsp.id   = id_t'(m);
    rsp.data = '0;
    found    = 1'b0;
    if (req.op == OpReadShared) begin
      for (int p = group_base(m); p < group_base(m) + NoMasterPerGroup; p++) begin
        if (!found && p != m && cache_store.exists(cache_key(p, req.addr))) begin
          rsp.data = cache_store[cache_key(p, req.addr)];
          found    = 1'b1;
        end
      end
    end
    if (!found && req.op inside {OpReadShared, OpReadNoSnoop}) rsp.data = mem_read(req.addr);
    return rsp;
  endfunction

  task automatic check_rsp(int m, ccu_rsp_t exp, ccu_rsp_t got, bit is_read);
    checks++;
    if (got.id !== exp.id) begin
      errors++;
      $display("** Error rsp_o[%0d].id: expected 0x%h, got 0x%h", m, exp.id, got.id);
    end
    if (is_read && got.data !== exp.data) begin
      errors++;
      $display("** Error rsp_o[%0d].data: expected 0x%h, got 0x%h", m, exp.data, got.data);
    end
  endtask

  // the snoop must come from a group peer that has a coherent request outstanding
  task automatic check_snoop(int m, snoop_req_t got);
    snoop_req_t exp;
    int         src;
    src = -1;
    exp = '0;
    for (int p = group_base(m); p < group_base(m) + NoMasterPerGroup; p++) begin
      if (p != m && busy[p] && cur_req[p].op inside {OpReadShared, OpWriteUnique}) begin
        if (src < 0 || cur_req[p].addr == got.addr) src = p;
      end
    end
    checks++;
    if (src < 0) begin
      errors++;
      $display("error: master %0d was snooped but no peer in its group is waiting", m);
    end else begin
      exp.addr       = cur_req[src].addr;
      exp.invalidate = (cur_req[src].op == OpWriteUnique);
      if (got !== exp) begin
        errors++;
        $display("** Error snoop_o[%0d]: expected 0x%h, got 0x%h", m, exp, got);
      end
    end
  endtask

  // a memory request must carry the outstanding request of the master named by its id
  task automatic check_mem_req(mem_req_t got);
    mem_req_t exp;
    int       m;
    m   = int'(got.id);
    exp = '0;
    checks++;
    if (m >= NoMasters || !busy[m]) begin
      errors++;
      $display("error: memory request carries id %0d, which has no request outstanding",
               got.id);
    end else begin
      exp.write = (cur_req[m].op inside {OpWriteNoSnoop, OpWriteUnique});
      exp.addr  = cur_req[m].addr;
      exp.data  = cur_req[m].data;
      exp.id    = id_t'(m);
      if (got.write !== exp.write || got.addr !== exp.addr ||
          (exp.write && got.data !== exp.data)) begin
        errors++;
        $display("** Error mem_req_o: expected 0x%h, got 0x%h", exp, got);
      end
    end
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic launch(int m, ccu_op_e op, addr_t addr, data_t data);
    ccu_req_t req;
    req.op         = op;
    req.addr       = addr;
    req.data       = data;
    req_valid_i[m] = 1'b1;
    req_i[m]       = req;
    cur_req[m]     = req;
    exp_rsp[m]     = expect_rsp(m, req);
    exp_read[m]    = (op inside {OpReadNoSnoop, OpReadShared});
    busy[m]        = 1'b1;
  endtask

  task automatic wait_idle();
    while (busy != '0) @(posedge clk_i);
  endtask

  task automatic run_txn(int m, ccu_op_e op, addr_t addr, data_t data);
    @(negedge clk_i);
    launch(m, op, addr, data);
    @(negedge clk_i);
    req_valid_i = '0;
    wait_idle();
  endtask

  task automatic clear_counts();
    for (int m = 0; m < NoMasters; m++) begin
      snoop_count[m] = 0;
      mem_count[m]   = 0;
    end
  endtask

  task automatic end_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  // each cache answers its one pending snoop after 1 to 3 cycles
  initial begin : cache_model
    int         wait_cnt [NoMasters];
    snoop_req_t held [NoMasters];
    line_key_t  key;
    bit         hit;
    for (int m = 0; m < NoMasters; m++) wait_cnt[m] = 0;
    forever begin
      @(negedge clk_i);
      for (int m = 0; m < NoMasters; m++) begin
        snoop_rsp_valid_i[m] = 1'b0;
        if (wait_cnt[m] > 0) begin
          wait_cnt[m]--;
          if (wait_cnt[m] == 0) begin
            key                      = cache_key(m, held[m].addr);
            hit                      = (cache_store.exists(key) != 0);
            snoop_rsp_valid_i[m]     = 1'b1;
            snoop_rsp_i[m].hit       = hit;
            snoop_rsp_i[m].data      = hit ? cache_store[key] : '0;
            if (hit && held[m].invalidate) cache_store.delete(key);
          end
        end
        if (snoop_valid_o[m]) begin
          check_snoop(m, snoop_o[m]);
          snoop_count[m]++;
          held[m]     = snoop_o[m];
          wait_cnt[m] = 1 + int'($urandom % 3);
        end
      end
    end
  end

  // memory answers ready requests one per cycle, so random delays reorder them
  initial begin : memory_model
    mem_job_t job;
    int       pick;
    forever begin
      @(negedge clk_i);
      cycle_cnt++;
      mem_rsp_valid_i = 1'b0;
      pick = -1;
      for (int i = 0; i < mem_jobs.size(); i++) begin
        if (pick < 0 && mem_jobs[i].due <= cycle_cnt) pick = i;
      end
      if (pick >= 0) begin
        job = mem_jobs[pick];
        mem_jobs.delete(pick);
        if (job.req.write) mem_store[job.req.addr] = job.req.data;
        mem_rsp_valid_i = 1'b1;
        mem_rsp_i.id    = job.req.id;
        mem_rsp_i.data  = mem_read(job.req.addr);
      end
      if (mem_valid_o) begin
        check_mem_req(mem_req_o);
        if (int'(mem_req_o.id) < NoMasters) mem_count[int'(mem_req_o.id)]++;
        job.req = mem_req_o;
        job.due = cycle_cnt + 1 + ($urandom % 4);
        mem_jobs.push_back(job);
      end
    end
  end

  initial begin : response_check
    forever begin
      @(negedge clk_i);
      for (int m = 0; m < NoMasters; m++) begin
        if (rsp_valid_o[m]) begin
          if (!busy[m]) begin
            errors++;
            $display("error: master %0d got a response with no request outstanding", m);
          end else begin
            check_rsp(m, exp_rsp[m], rsp_o[m], exp_read[m]);
            busy[m] = 1'b0;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NumTxn * 40) @(posedge clk_i);
    $display("error: run did not finish within %0d cycles", NumTxn * 40);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    int          e0;
    int          base;
    void'($urandom(78));
    rst_n_i     = 1'b0;
    req_valid_i = '0;
    req_i       = '0;
    clear_counts();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    e0 = errors;
    repeat (10) begin
      @(negedge clk_i);
      check_value("rsp_valid_o", '0, 32'(rsp_valid_o));
      check_value("snoop_valid_o", '0, 32'(snoop_valid_o));
      check_value("mem_valid_o", '0, 32'(mem_valid_o));
    end
    end_test("quiet after reset", e0);

    e0 = errors;
    clear_counts();
    for (int m = 0; m < NoMasters; m++) begin
      run_txn(m, OpWriteNoSnoop, addr_t'(16'h0100 + m), data_t'(32'ha5000000 + m));
      run_txn(m, OpReadNoSnoop, addr_t'(16'h0100 + m), '0);
      run_txn(m, OpReadNoSnoop, addr_t'(16'h0180 + m), '0);
    end
    for (int m = 0; m < NoMasters; m++) begin
      check_value($sformatf("snoop count of master %0d", m), 0, snoop_count[m]);
    end
    end_test("non-snooping reads and writes", e0);

    e0 = errors;
    for (int g = 0; g < NoGroups; g++) begin
      base = g * NoMasterPerGroup;
      clear_counts();
      cache_store[cache_key(base + 1, addr_t'(16'h0200 + g))] = data_t'(32'hbeef0000 + g);
      run_txn(base, OpReadShared, addr_t'(16'h0200 + g), '0);
      check_value($sformatf("memory requests of master %0d", base), 0, mem_count[base]);
      check_value($sformatf("snoop count of master %0d", base + 1), 1, snoop_count[base + 1]);
    end
    end_test("ReadShared peer hit", e0);

    e0 = errors;
    for (int g = 0; g < NoGroups; g++) begin
      base = g * NoMasterPerGroup;
      clear_counts();
      run_txn(base + 1, OpReadShared, addr_t'(16'h0300 + g), '0);
      for (int m = 0; m < NoMasters; m++) begin
        check_value($sformatf("snoop count of master %0d", m), (m == base) ? 1 : 0,
                    snoop_count[m]);
      end
      check_value($sformatf("memory requests of master %0d", base + 1), 1, mem_count[base + 1]);
    end
    end_test("ReadShared miss", e0);

    e0 = errors;
    for (int g = 0; g < NoGroups; g++) begin
      base = g * NoMasterPerGroup;
      clear_counts();
      cache_store[cache_key(base + 1, addr_t'(16'h0400 + g))] = data_t'(32'h0bad0000 + g);
      run_txn(base, OpWriteUnique, addr_t'(16'h0400 + g), data_t'(32'hc0de0000 + g));
      check_value($sformatf("snoop count of master %0d", base + 1), 1, snoop_count[base + 1]);
      check_value($sformatf("line of master %0d after invalidate", base + 1), 0,
                  cache_store.exists(cache_key(base + 1, addr_t'(16'h0400 + g))));
      run_txn(base + 1, OpReadShared, addr_t'(16'h0400 + g), '0);
      check_value($sformatf("memory requests of master %0d", base + 1), 1, mem_count[base + 1]);
    end
    end_test("WriteUnique invalidate", e0);

    // every master works in its own region, so concurrent traffic stays order independent
    e0 = errors;
    for (int m = 0; m < NoMasters; m++) begin
      for (int a = 0; a < 8; a++) begin
        for (int p = group_base(m); p < group_base(m) + NoMasterPerGroup; p++) begin
          if (p != m && ($urandom % 2) == 1) cache_store[cache_key(p, region_addr(m, a))] = $urandom;
        end
      end
    end
    repeat (NumRounds) begin
      @(negedge clk_i);
      for (int m = 0; m < NoMasters; m++) begin
        launch(m, ccu_op_e'(2'($urandom % 4)), region_addr(m, int'($urandom % 8)), $urandom);
      end
      @(negedge clk_i);
      req_valid_i = '0;
      wait_idle();
    end
    end_test("random mixed traffic", e0);

    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
